// File: vlog.f
fpu_format_pkg.sv
fpu_op_pkg.sv
fp_operand_decode.sv
fp_compare_unit.sv
fp_sign_move_unit.sv
fpu_issue_stage.sv
fpu_result_queue.sv
fpu_misc.sv
fpu_misc_sva.sv
tb_fpu_misc.sv

// File: run.sh
#!/bin/sh
# compile and run the FP unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_fpu_misc -f vlog.f -o sim_fpu_misc
./obj_dir/sim_fpu_misc

// File: tb_fpu_misc.sv
// Testbench for the single-cycle FP unit. Issues a table of operations
// under issue credits, returns result credits after random delays and
// checks every result in issue order against the expected table values.
// Run through vlog.f; the run ends in $finish on success, $fatal otherwise.
module tb_fpu_misc import fpu_format_pkg::*, fpu_op_pkg::*;;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TAG_W       = 5;
	localparam int QUEUE_DEPTH = 4;
	localparam int OUT_CREDITS = 2;
	localparam int N_ROWS      = 32;	// one tag per row
	localparam int TIMEOUT     = 16 + 8 * N_ROWS;

	typedef struct packed {
		fpu_op_t     op;
		fmode_t      mode;
		fprec_t      prec;
		logic        xfer_dir;
		logic [63:0] fr1;
		logic [63:0] fr2;
		logic [63:0] ir1;
		logic [63:0] exp_res;
		logic        exp_fp;
		logic        exp_nv;
	} row_t;

	logic clk = 1'b0;
	logic rst_n;
	logic in_valid;
	fpu_op_t op;
	fmode_t mode;
	fprec_t prec;
	logic xfer_dir;
	logic [TAG_W-1:0] rd;
	logic [63:0] fr1, fr2, ir1;
	logic res_credit;
	logic issue_credit;
	logic res_valid;
	logic [63:0] result;
	logic [TAG_W-1:0] res_rd;
	logic res_fp;
	fflags_t res_exceptions;

	row_t rows [N_ROWS];
	int n_loaded = 0;
	int n_issued = 0;
	int n_checked = 0;
	int credits = QUEUE_DEPTH;	// scheduler side issue credits
	int cycle_cnt = 0;
	int owed = 0;	// result credits the consumer still has to return
	int hold = 0;
	integer seed = 16152;

	always #5 clk = ~clk;

	fpu_misc #(
		.TAG_W(TAG_W), .QUEUE_DEPTH(QUEUE_DEPTH), .OUT_CREDITS(OUT_CREDITS)
	) u_fpu_misc (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .op(op), .mode(mode),
		.prec(prec), .xfer_dir(xfer_dir), .rd(rd), .fr1(fr1), .fr2(fr2), .ir1(ir1),
		.res_credit(res_credit), .issue_credit(issue_credit), .res_valid(res_valid),
		.result(result), .res_rd(res_rd), .res_fp(res_fp),
		.res_exceptions(res_exceptions)
	);

	function automatic logic [63:0] box_s(input logic [31:0] v);
		return {32'hffff_ffff, v};
	endfunction

	task automatic put_row(input fpu_op_t o, input fmode_t m, input fprec_t p,
			input logic x, input logic [63:0] a, input logic [63:0] b,
			input logic [63:0] i, input logic [63:0] res, input logic fp,
			input logic nv);
		rows[n_loaded] = {o, m, p, x, a, b, i, res, fp, nv};
		n_loaded = n_loaded + 1;
	endtask

	task automatic load_table();
		// sign injection
		put_row(op_fsgn, mode_j, prec_s, 0, box_s(32'h3f80_0000), box_s(32'hbf80_0000), 0,
			box_s(32'hbf80_0000), 1, 0);
		put_row(op_fsgn, mode_jx, prec_s, 0, box_s(32'h3f80_0000), box_s(32'hbf80_0000), 0,
			box_s(32'hbf80_0000), 1, 0);
		put_row(op_fsgn, mode_jn, prec_d, 0, 64'h4000_0000_0000_0000,
			64'h3ff0_0000_0000_0000, 0, 64'hc000_0000_0000_0000, 1, 0);
		put_row(op_fsgn, mode_jx, prec_d, 0, 64'hc000_0000_0000_0000,
			64'h3ff0_0000_0000_0000, 0, 64'hc000_0000_0000_0000, 1, 0);
		// compares, integer result
		put_row(op_fcmp, mode_eq, prec_d, 0, 64'h3ff0_0000_0000_0000,
			64'h3ff0_0000_0000_0000, 0, 64'd1, 0, 0);
		put_row(op_fcmp, mode_lt, prec_d, 0, 64'hc000_0000_0000_0000,
			64'h3ff0_0000_0000_0000, 0, 64'd1, 0, 0);
		put_row(op_fcmp, mode_eq, prec_s, 0, box_s(32'h0), box_s(32'h8000_0000), 0, 64'd1, 0, 0);
		put_row(op_fcmp, mode_le, prec_s, 0, box_s(32'h8000_0000), box_s(32'h0), 0, 64'd1, 0, 0);
		put_row(op_fcmp, mode_lt, prec_s, 0, box_s(32'h7fc0_0000), box_s(32'h3f80_0000), 0,
			64'd0, 0, 1);	// qnan in lt is invalid
		put_row(op_fcmp, mode_eq, prec_s, 0, box_s(32'h7fc0_0000), box_s(32'h3f80_0000), 0,
			64'd0, 0, 0);
		put_row(op_fcmp, mode_eq, prec_d, 0, 64'h7ff0_0000_0000_0001,
			64'h3ff0_0000_0000_0000, 0, 64'd0, 0, 1);
		put_row(op_fcmp, mode_le, prec_d, 0, 64'h4000_0000_0000_0000,
			64'h3ff0_0000_0000_0000, 0, 64'd0, 0, 0);
		// min and max
		put_row(op_fminmax, mode_min, prec_d, 0, 64'h3ff0_0000_0000_0000,
			64'hc000_0000_0000_0000, 0, 64'hc000_0000_0000_0000, 1, 0);
		put_row(op_fminmax, mode_max, prec_d, 0, 64'h3ff0_0000_0000_0000,
			64'hc000_0000_0000_0000, 0, 64'h3ff0_0000_0000_0000, 1, 0);
		put_row(op_fminmax, mode_min, prec_s, 0, box_s(32'h0), box_s(32'h8000_0000), 0,
			box_s(32'h8000_0000), 1, 0);
		put_row(op_fminmax, mode_max, prec_s, 0, box_s(32'h8000_0000), box_s(32'h0), 0,
			box_s(32'h0), 1, 0);
		put_row(op_fminmax, mode_min, prec_s, 0, box_s(32'h7fc0_0000), box_s(32'h4000_0000), 0,
			box_s(32'h4000_0000), 1, 0);
		put_row(op_fminmax, mode_max, prec_s, 0, box_s(32'h3f80_0000), box_s(32'h7f80_0001), 0,
			box_s(32'h3f80_0000), 1, 1);
		put_row(op_fminmax, mode_min, prec_d, 0, 64'hfff8_0000_0000_0001,
			64'h7ff0_0000_0000_0001, 0, 64'h7ff8_0000_0000_0000, 1, 1);
		put_row(op_fminmax, mode_max, prec_s, 0, 64'h0000_0000_3f80_0000,
			box_s(32'h4000_0000), 0, box_s(32'h4000_0000), 1, 0);	// unboxed reads as qnan
		// fclass, one bit per class
		put_row(op_fclass, 2'd0, prec_d, 0, 64'hfff0_0000_0000_0000, 0, 0, 64'h001, 0, 0);
		put_row(op_fclass, 2'd0, prec_d, 0, 64'hbff0_0000_0000_0000, 0, 0, 64'h002, 0, 0);
		put_row(op_fclass, 2'd0, prec_d, 0, 64'h8000_0000_0000_0001, 0, 0, 64'h004, 0, 0);
		put_row(op_fclass, 2'd0, prec_s, 0, box_s(32'h8000_0000), 0, 0, 64'h008, 0, 0);
		put_row(op_fclass, 2'd0, prec_s, 0, box_s(32'h0000_0000), 0, 0, 64'h010, 0, 0);
		put_row(op_fclass, 2'd0, prec_s, 0, box_s(32'h0000_0001), 0, 0, 64'h020, 0, 0);
		put_row(op_fclass, 2'd0, prec_s, 0, box_s(32'h3f80_0000), 0, 0, 64'h040, 0, 0);
		put_row(op_fclass, 2'd0, prec_s, 0, box_s(32'h7f80_0000), 0, 0, 64'h080, 0, 0);
		put_row(op_fclass, 2'd0, prec_s, 0, box_s(32'h7f80_0001), 0, 0, 64'h100, 0, 0);
		put_row(op_fclass, 2'd0, prec_d, 0, 64'h7ff8_0000_0000_0000, 0, 0, 64'h200, 0, 0);
		// moves between register files
		put_row(op_fmv, 2'd0, prec_s, 1, 0, 0, 64'h0123_4567_89ab_cdef,
			64'hffff_ffff_89ab_cdef, 1, 0);
		put_row(op_fmv, 2'd0, prec_s, 0, box_s(32'h4049_0fdb), 0, 0,
			64'h0000_0000_4049_0fdb, 0, 0);
	endtask

	task automatic issue_row(input int i);
		in_valid <= 1'b1;
		op <= rows[i].op;
		mode <= rows[i].mode;
		prec <= rows[i].prec;
		xfer_dir <= rows[i].xfer_dir;
		rd <= TAG_W'(i);
		fr1 <= rows[i].fr1;
		fr2 <= rows[i].fr2;
		ir1 <= rows[i].ir1;
	endtask

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] want);
		if (got !== want) begin
			$display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, what, got, want);
			$display("Checks failed");
			$fatal(1, "wrong value on %s", what);
		end
	endtask

	task automatic compare_result(input int i);
		check_value("res_rd", {{(64 - TAG_W){1'b0}}, res_rd}, 64'(i % (1 << TAG_W)));
		check_value("result", result, rows[i].exp_res);
		check_value("res_fp", {63'b0, res_fp}, {63'b0, rows[i].exp_fp});
		check_value("res_exceptions", {59'b0, res_exceptions}, {59'b0, rows[i].exp_nv, 4'b0});
	endtask

	// writeback consumer, one credit back per result after 0 to 3 cycles
	always @(posedge clk) begin
		if (!rst_n) begin
			owed = 0;
			hold = $random(seed) & 3;
			res_credit <= 1'b0;
		end else begin
			res_credit <= 1'b0;
			if (res_valid)
				owed = owed + 1;
			if (owed > 0) begin
				if (hold == 0) begin
					res_credit <= 1'b1;
					owed = owed - 1;
					hold = $random(seed) & 3;
				end else begin
					hold = hold - 1;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT) begin
			$display("Checks failed");
			$fatal(1, "timeout after %0d cycles, %0d of %0d results seen",
				cycle_cnt, n_checked, N_ROWS);
		end
	end

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		op = op_fsgn;
		mode = '0;
		prec = prec_s;
		xfer_dir = 1'b0;
		rd = '0;
		fr1 = '0;
		fr2 = '0;
		ir1 = '0;
		res_credit = 1'b0;
		load_table();
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		while (n_checked < N_ROWS) begin
			@(posedge clk);
			if (issue_credit)
				credits = credits + 1;
			if (res_valid) begin
				compare_result(n_checked);
				n_checked = n_checked + 1;
			end
			if (n_issued < N_ROWS && credits > 0) begin
				issue_row(n_issued);
				credits = credits - 1;
				n_issued = n_issued + 1;
			end else begin
				in_valid <= 1'b0;
			end
		end
		in_valid <= 1'b0;
		repeat (8) begin	// nothing more may come out
			@(posedge clk);
			if (issue_credit)
				credits = credits + 1;
			if (res_valid) begin
				$display("Checks failed");
				$fatal(1, "result seen after the last expected one");
			end
		end
		if (credits == QUEUE_DEPTH) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Checks failed");
			$fatal(1, "only %0d of %0d issue credits came back", credits, QUEUE_DEPTH);
		end
	end

endmodule

// File: fpu_misc_sva.sv
// Credit protocol assertions for the result queue, bound into every
// fpu_result_queue instance. Keeps its own credit and occupancy counts
// from the queue's ports.
module fpu_misc_sva #(
	parameter int QUEUE_DEPTH = 4,
	parameter int OUT_CREDITS = 2,
	parameter int CRD_W       = 2
) (
	input logic             clk,
	input logic             rst_n,
	input logic             s_valid,
	input logic             res_valid,
	input logic             res_credit,
	input logic             issue_credit,
	input logic [CRD_W-1:0] credit_cnt
);
	timeunit 1ns;
	timeprecision 1ps;

	int crd_model;	// result credits as seen on the ports
	int held;	// entries stored and not yet handed back upstream

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			crd_model <= OUT_CREDITS;
			held <= 0;
		end else begin
			crd_model <= crd_model + int'(res_credit) - int'(res_valid);
			held <= held + int'(s_valid) - int'(issue_credit);
		end
	end

	valid_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> crd_model > 0)
		else $error("result sent while the credit count is zero");

	credit_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		credit_cnt <= CRD_W'(OUT_CREDITS))
		else $error("credit count above its initial value");

	// an issue credit only goes back for an entry that was stored
	issue_credit_on_pop: assert property (@(posedge clk) disable iff (!rst_n)
		issue_credit |-> held > 0)
		else $error("issue credit returned with no entry held");

	queue_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		held <= QUEUE_DEPTH)
		else $error("more entries stored than the queue holds");

endmodule

bind fpu_result_queue fpu_misc_sva #(
	.QUEUE_DEPTH(QUEUE_DEPTH), .OUT_CREDITS(OUT_CREDITS), .CRD_W(CRD_W)
) u_sva (
	.clk(clk), .rst_n(rst_n), .s_valid(s_valid), .res_valid(res_valid),
	.res_credit(res_credit), .issue_credit(issue_credit), .credit_cnt(credit_cnt)
);

// File: fpu_misc.sv
// Top level of the single-cycle FP unit: sign injection, min/max,
// compares, fclass and moves. Issue register, two operand decoders,
// the compare and sign/move units, and the credited result queue.
module fpu_misc import fpu_format_pkg::*, fpu_op_pkg::*; #(
	parameter int TAG_W       = 5,
	parameter int QUEUE_DEPTH = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  fpu_op_t          op,
	input  fmode_t           mode,
	input  fprec_t           prec,
	input  logic             xfer_dir,
	input  logic [TAG_W-1:0] rd,
	input  logic [xlen-1:0]  fr1,
	input  logic [xlen-1:0]  fr2,
	input  logic [xlen-1:0]  ir1,
	input  logic             res_credit,
	output logic             issue_credit,
	output logic             res_valid,
	output logic [xlen-1:0]  result,
	output logic [TAG_W-1:0] res_rd,
	output logic             res_fp,
	output fflags_t          res_exceptions
);

	logic             s_valid;
	fpu_op_t          s_op;
	fmode_t           s_mode;
	fprec_t           s_prec;
	logic             s_xfer_dir;
	logic [TAG_W-1:0] s_rd;
	logic [xlen-1:0]  s_fr1, s_fr2, s_ir1;

	logic                  a_sign, a_is_zero, a_is_sub, a_is_inf, a_is_nan, a_is_snan;
	logic [d_exp_bits-1:0] a_exp;
	logic [d_man_bits-1:0] a_man;
	logic                  b_sign, b_is_zero, b_is_inf, b_is_nan, b_is_snan;
	logic [d_exp_bits-1:0] b_exp;
	logic [d_man_bits-1:0] b_man;

	logic [xlen-1:0] cmp_result, sm_result;
	logic            cmp_fp, cmp_nv, sm_fp;

	fpu_issue_stage #(.TAG_W(TAG_W)) u_issue (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid),
		.op(op), .mode(mode), .prec(prec), .xfer_dir(xfer_dir), .rd(rd),
		.fr1(fr1), .fr2(fr2), .ir1(ir1),
		.s_valid(s_valid), .s_op(s_op), .s_mode(s_mode), .s_prec(s_prec),
		.s_xfer_dir(s_xfer_dir), .s_rd(s_rd),
		.s_fr1(s_fr1), .s_fr2(s_fr2), .s_ir1(s_ir1)
	);

	fp_operand_decode u_dec_a (
		.val(s_fr1), .prec(s_prec), .sign(a_sign), .exp(a_exp), .man(a_man),
		.is_zero(a_is_zero), .is_sub(a_is_sub), .is_inf(a_is_inf),
		.is_nan(a_is_nan), .is_snan(a_is_snan)
	);

	// operand 2 subnormal flag has no consumer
	fp_operand_decode u_dec_b (
		.val(s_fr2), .prec(s_prec), .sign(b_sign), .exp(b_exp), .man(b_man),
		.is_zero(b_is_zero), .is_sub(), .is_inf(b_is_inf),
		.is_nan(b_is_nan), .is_snan(b_is_snan)
	);

	fp_compare_unit u_cmp (
		.s_op(s_op), .s_mode(s_mode), .s_prec(s_prec), .s_fr1(s_fr1), .s_fr2(s_fr2),
		.a_sign(a_sign), .a_exp(a_exp), .a_man(a_man), .a_is_zero(a_is_zero),
		.a_is_inf(a_is_inf), .a_is_nan(a_is_nan), .a_is_snan(a_is_snan),
		.b_sign(b_sign), .b_exp(b_exp), .b_man(b_man), .b_is_zero(b_is_zero),
		.b_is_inf(b_is_inf), .b_is_nan(b_is_nan), .b_is_snan(b_is_snan),
		.cmp_result(cmp_result), .cmp_fp(cmp_fp), .cmp_nv(cmp_nv)
	);

	fp_sign_move_unit u_sm (
		.s_op(s_op), .s_mode(s_mode), .s_prec(s_prec), .s_xfer_dir(s_xfer_dir),
		.s_fr1(s_fr1), .s_ir1(s_ir1), .a_sign(a_sign), .a_is_zero(a_is_zero),
		.a_is_sub(a_is_sub), .a_is_inf(a_is_inf), .a_is_nan(a_is_nan),
		.a_is_snan(a_is_snan), .b_sign(b_sign),
		.sm_result(sm_result), .sm_fp(sm_fp)
	);

	fpu_result_queue #(
		.TAG_W(TAG_W), .QUEUE_DEPTH(QUEUE_DEPTH), .OUT_CREDITS(OUT_CREDITS)
	) u_queue (
		.clk(clk), .rst_n(rst_n), .s_valid(s_valid), .s_op(s_op), .s_rd(s_rd),
		.cmp_result(cmp_result), .cmp_fp(cmp_fp), .cmp_nv(cmp_nv),
		.sm_result(sm_result), .sm_fp(sm_fp), .res_credit(res_credit),
		.res_valid(res_valid), .result(result), .res_rd(res_rd), .res_fp(res_fp),
		.res_exceptions(res_exceptions), .issue_credit(issue_credit)
	);

endmodule

// File: fpu_result_queue.sv
// Result FIFO between the units and writeback. Picks the unit by op,
// stores one entry per s_valid and sends the oldest out while result
// credits remain. Each entry leaving returns an issue credit upstream.
module fpu_result_queue import fpu_format_pkg::*, fpu_op_pkg::*; #(
	parameter int TAG_W       = 5,
	parameter int QUEUE_DEPTH = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             s_valid,
	input  fpu_op_t          s_op,
	input  logic [TAG_W-1:0] s_rd,
	input  logic [xlen-1:0]  cmp_result,
	input  logic             cmp_fp,
	input  logic             cmp_nv,
	input  logic [xlen-1:0]  sm_result,
	input  logic             sm_fp,
	input  logic             res_credit,
	output logic             res_valid,
	output logic [xlen-1:0]  result,
	output logic [TAG_W-1:0] res_rd,
	output logic             res_fp,
	output fflags_t          res_exceptions,
	output logic             issue_credit
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam int CRD_W = $clog2(OUT_CREDITS + 1);

	logic [xlen-1:0]  mem_result [QUEUE_DEPTH];
	logic [TAG_W-1:0] mem_rd [QUEUE_DEPTH];
	logic             mem_fp [QUEUE_DEPTH];
	logic             mem_nv [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] used_cnt;
	logic [CRD_W-1:0] credit_cnt;
	logic             from_cmp;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(QUEUE_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign from_cmp = s_op == op_fcmp || s_op == op_fminmax;

	// no full check, issue credits keep a slot free
	always_ff @(posedge clk) begin
		if (s_valid) begin
			mem_result[wr_ptr] <= from_cmp ? cmp_result : sm_result;
			mem_rd[wr_ptr] <= s_rd;
			mem_fp[wr_ptr] <= from_cmp ? cmp_fp : sm_fp;
			mem_nv[wr_ptr] <= from_cmp & cmp_nv;	// sign/move ops never raise nv
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used_cnt <= '0;
			credit_cnt <= CRD_W'(OUT_CREDITS);
		end else begin
			if (s_valid)
				wr_ptr <= ptr_inc(wr_ptr);
			if (res_valid)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({s_valid, res_valid})
				2'b10:   used_cnt <= used_cnt + 1'b1;
				2'b01:   used_cnt <= used_cnt - 1'b1;
				default: used_cnt <= used_cnt;
			endcase
			case ({res_credit, res_valid})
				2'b10:   credit_cnt <= credit_cnt + 1'b1;
				2'b01:   credit_cnt <= credit_cnt - 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	assign res_valid = used_cnt != '0 && credit_cnt != '0;	// pops on this edge
	assign issue_credit = res_valid;

	assign result = mem_result[rd_ptr];
	assign res_rd = mem_rd[rd_ptr];
	assign res_fp = mem_fp[rd_ptr];

	always_comb begin
		res_exceptions.nv = mem_nv[rd_ptr];
		res_exceptions.dz = 1'b0;
		res_exceptions.of = 1'b0;
		res_exceptions.uf = 1'b0;
		res_exceptions.nx = 1'b0;
	end

endmodule

// File: fpu_issue_stage.sv
// Input register of the FP unit. Holds an accepted operation for one
// cycle so the decoders and units see stable operands.
module fpu_issue_stage import fpu_format_pkg::*, fpu_op_pkg::*; #(
	parameter int TAG_W = 5
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  fpu_op_t          op,
	input  fmode_t           mode,
	input  fprec_t           prec,
	input  logic             xfer_dir,
	input  logic [TAG_W-1:0] rd,
	input  logic [xlen-1:0]  fr1,
	input  logic [xlen-1:0]  fr2,
	input  logic [xlen-1:0]  ir1,
	output logic             s_valid,
	output fpu_op_t          s_op,
	output fmode_t           s_mode,
	output fprec_t           s_prec,
	output logic             s_xfer_dir,
	output logic [TAG_W-1:0] s_rd,
	output logic [xlen-1:0]  s_fr1,
	output logic [xlen-1:0]  s_fr2,
	output logic [xlen-1:0]  s_ir1
);

	always_ff @(posedge clk) begin
		if (!rst_n)
			s_valid <= 1'b0;
		else
			s_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin	// payload only moves on an issue
			s_op <= op;
			s_mode <= mode;
			s_prec <= prec;
			s_xfer_dir <= xfer_dir;
			s_rd <= rd;
			s_fr1 <= fr1;
			s_fr2 <= fr2;
			s_ir1 <= ir1;
		end
	end

endmodule

// File: fp_sign_move_unit.sv
// Sign injection, FCLASS and the FMV moves between register files.
// Purely combinational, fed from the issue stage and operand 1's decoder.
module fp_sign_move_unit import fpu_format_pkg::*, fpu_op_pkg::*; (
	input  fpu_op_t         s_op,
	input  fmode_t          s_mode,
	input  fprec_t          s_prec,
	input  logic            s_xfer_dir,
	input  logic [xlen-1:0] s_fr1,
	input  logic [xlen-1:0] s_ir1,
	input  logic            a_sign,
	input  logic            a_is_zero,
	input  logic            a_is_sub,
	input  logic            a_is_inf,
	input  logic            a_is_nan,
	input  logic            a_is_snan,
	input  logic            b_sign,
	output logic [xlen-1:0] sm_result,
	output logic            sm_fp
);

	logic            new_sign;
	logic [xlen-1:0] sgn_res;
	logic [xlen-1:0] mv_res;
	fclass_t         cls;

	always_comb begin
		case (s_mode)
			mode_j:  new_sign = b_sign;
			mode_jn: new_sign = !b_sign;
			mode_jx: new_sign = a_sign ^ b_sign;
			default: new_sign = b_sign;
		endcase
	end

	// upper half of an S value is left as it came in
	assign sgn_res = (s_prec == prec_s) ?
		{s_fr1[xlen-1:xlen/2], new_sign, s_fr1[xlen/2-2:0]} :
		{new_sign, s_fr1[xlen-2:0]};

	always_comb begin
		cls = '0;
		if (a_is_nan) begin
			if (a_is_snan)
				cls[fc_snan] = 1'b1;
			else
				cls[fc_qnan] = 1'b1;
		end else if (a_is_inf) begin
			cls[a_sign ? fc_neg_inf : fc_pos_inf] = 1'b1;
		end else if (a_is_zero) begin
			cls[a_sign ? fc_neg_zero : fc_pos_zero] = 1'b1;
		end else if (a_is_sub) begin
			cls[a_sign ? fc_neg_sub : fc_pos_sub] = 1'b1;
		end else begin
			cls[a_sign ? fc_neg_norm : fc_pos_norm] = 1'b1;
		end
	end

	always_comb begin
		if (s_xfer_dir) begin	// int -> fp
			mv_res = (s_prec == prec_s) ? {nan_box, s_ir1[xlen/2-1:0]} : s_ir1;
		end else begin	// fp -> int, S sign-extended
			mv_res = (s_prec == prec_s) ?
				{{(xlen/2){s_fr1[xlen/2-1]}}, s_fr1[xlen/2-1:0]} : s_fr1;
		end
	end

	always_comb begin
		case (s_op)
			op_fsgn: begin
				sm_result = sgn_res;
				sm_fp = 1'b1;
			end
			op_fclass: begin
				sm_result = {{(xlen - $bits(fclass_t)){1'b0}}, cls};
				sm_fp = 1'b0;
			end
			op_fmv: begin
				sm_result = mv_res;
				sm_fp = s_xfer_dir;
			end
			default: begin
				sm_result = '0;
				sm_fp = 1'b0;
			end
		endcase
	end

endmodule

// File: fp_compare_unit.sv
// FMIN/FMAX and FEQ/FLT/FLE on two decoded operands, with the invalid flag.
// Purely combinational, fed from the issue stage registers.
module fp_compare_unit import fpu_format_pkg::*, fpu_op_pkg::*; (
	input  fpu_op_t               s_op,
	input  fmode_t                s_mode,
	input  fprec_t                s_prec,
	input  logic [xlen-1:0]       s_fr1,
	input  logic [xlen-1:0]       s_fr2,
	input  logic                  a_sign,
	input  logic [d_exp_bits-1:0] a_exp,
	input  logic [d_man_bits-1:0] a_man,
	input  logic                  a_is_zero,
	input  logic                  a_is_inf,
	input  logic                  a_is_nan,
	input  logic                  a_is_snan,
	input  logic                  b_sign,
	input  logic [d_exp_bits-1:0] b_exp,
	input  logic [d_man_bits-1:0] b_man,
	input  logic                  b_is_zero,
	input  logic                  b_is_inf,
	input  logic                  b_is_nan,
	input  logic                  b_is_snan,
	output logic [xlen-1:0]       cmp_result,
	output logic                  cmp_fp,
	output logic                  cmp_nv
);

	logic eq, lt;
	logic any_nan, any_snan;
	logic cmp_bit;
	logic pick_low, pick_a;
	logic [xlen-1:0] canon_nan;

	assign any_nan = a_is_nan | b_is_nan;
	assign any_snan = a_is_snan | b_is_snan;
	assign canon_nan = (s_prec == prec_d) ? d_canon_nan : s_canon_nan;

	// ordering of two non-NaN operands, a against b
	always_comb begin
		if (a_is_zero && b_is_zero) begin	// -0 == +0
			eq = 1'b1;
			lt = 1'b0;
		end else if (a_sign != b_sign) begin
			eq = 1'b0;
			lt = a_sign;
		end else if (a_is_inf || b_is_inf) begin
			eq = a_is_inf && b_is_inf;
			lt = !eq && (a_is_inf == a_sign);
		end else if (a_exp != b_exp) begin
			eq = 1'b0;
			lt = (a_exp < b_exp) ^ a_sign;	// magnitude order flips for negatives
		end else if (a_man != b_man) begin
			eq = 1'b0;
			lt = (a_man < b_man) ^ a_sign;
		end else begin
			eq = 1'b1;
			lt = 1'b0;
		end
	end

	always_comb begin
		case (s_mode)
			mode_le: cmp_bit = (eq | lt) & !any_nan;
			mode_lt: cmp_bit = lt & !any_nan;
			mode_eq: cmp_bit = eq & !any_nan;
			default: cmp_bit = 1'b0;
		endcase
	end

	// on equal values take a when negative so min(-0,+0) is -0
	assign pick_low = eq ? a_sign : lt;

	always_comb begin
		case (s_mode)
			mode_min: pick_a = pick_low;
			mode_max: pick_a = !pick_low;
			default:  pick_a = pick_low;
		endcase
	end

	always_comb begin
		if (s_op == op_fminmax) begin
			cmp_fp = 1'b1;
			cmp_nv = any_snan;
			case ({a_is_nan, b_is_nan})
				2'b01:   cmp_result = s_fr1;	// other operand wins over a nan
				2'b10:   cmp_result = s_fr2;
				2'b11:   cmp_result = canon_nan;
				default: cmp_result = pick_a ? s_fr1 : s_fr2;
			endcase
		end else begin
			cmp_fp = 1'b0;
			cmp_nv = any_snan | (any_nan & (s_mode != mode_eq));	// signalling compares
			cmp_result = {{(xlen - 1){1'b0}}, cmp_bit};
		end
	end

endmodule

// File: fp_operand_decode.sv
// Splits one register operand into sign, exponent, mantissa and class
// flags. S values are rebiased and left-aligned into the D field widths
// so the compare logic sees one format. A badly boxed S reads as qNaN.
module fp_operand_decode import fpu_format_pkg::*, fpu_op_pkg::*; (
	input  logic [xlen-1:0]       val,
	input  fprec_t                prec,
	output logic                  sign,
	output logic [d_exp_bits-1:0] exp,
	output logic [d_man_bits-1:0] man,
	output logic                  is_zero,
	output logic                  is_sub,
	output logic                  is_inf,
	output logic                  is_nan,
	output logic                  is_snan
);

	// S bias 127 moved up to D bias 1023
	localparam logic [d_exp_bits-1:0] bias_adj =
		d_exp_bits'((1 << (d_exp_bits - 1)) - (1 << (s_exp_bits - 1)));

	logic [s_exp_bits-1:0] s_exp;
	logic [s_man_bits-1:0] s_man;
	logic                  boxed;

	assign s_exp = val[s_man_bits +: s_exp_bits];
	assign s_man = val[s_man_bits-1:0];
	assign boxed = val[xlen-1:xlen/2] == nan_box;

	always_comb begin
		if (prec == prec_d) begin
			sign = val[xlen-1];
			exp = val[d_man_bits +: d_exp_bits];
			man = val[d_man_bits-1:0];
		end else if (!boxed) begin	// canonical qnan
			sign = 1'b0;
			exp = '1;
			man = {1'b1, {(d_man_bits - 1){1'b0}}};
		end else begin
			sign = val[s_exp_bits + s_man_bits];
			if (s_exp == '0) begin
				exp = '0;	// zero and subnormal keep exponent 0
			end else if (&s_exp) begin
				exp = '1;
			end else begin
				exp = {{(d_exp_bits - s_exp_bits){1'b0}}, s_exp} + bias_adj;
			end
			man = {s_man, {(d_man_bits - s_man_bits){1'b0}}};
		end
	end

	assign is_zero = exp == '0 && man == '0;
	assign is_sub  = exp == '0 && man != '0;
	assign is_inf  = &exp && man == '0;
	assign is_nan  = &exp && man != '0;
	assign is_snan = is_nan && !man[d_man_bits-1];	// quiet bit clear

endmodule

// File: fpu_op_pkg.sv
// Operation, mode and precision codes for the single-cycle FP unit,
// plus the layout of the IEEE exception flags.
// The scheduler, the issue stage and both units share these.
package fpu_op_pkg;

	typedef enum logic [3:0] {
		op_fsgn    = 4'd5,	// sign injection
		op_fminmax = 4'd6,
		op_fcmp    = 4'd12,
		op_fclass  = 4'd13,
		op_fmv     = 4'd14
	} fpu_op_t;

	typedef logic [1:0] fmode_t;

	// fsgn modes
	localparam fmode_t mode_j  = 2'd0;
	localparam fmode_t mode_jn = 2'd1;
	localparam fmode_t mode_jx = 2'd2;

	// fminmax modes
	localparam fmode_t mode_min = 2'd0;
	localparam fmode_t mode_max = 2'd1;

	// fcmp modes
	localparam fmode_t mode_le = 2'd0;
	localparam fmode_t mode_lt = 2'd1;
	localparam fmode_t mode_eq = 2'd2;

	typedef enum logic {
		prec_s = 1'b0,
		prec_d = 1'b1
	} fprec_t;

	// nv is the msb, nx the lsb
	typedef struct packed {
		logic nv;	// invalid
		logic dz;	// divide by zero
		logic of;	// overflow
		logic uf;	// underflow
		logic nx;	// inexact
	} fflags_t;

endpackage

// File: fpu_format_pkg.sv
// IEEE 754 field layout shared by the single-cycle FP unit.
// S values sit NaN-boxed in the low half of a 64-bit register.
// Also holds the canonical NaNs and the fclass bit positions.
package fpu_format_pkg;

	localparam int xlen = 64;	// FP and integer register width

	localparam int s_exp_bits = 8;
	localparam int s_man_bits = 23;
	localparam int d_exp_bits = 11;
	localparam int d_man_bits = 52;

	// upper half of a valid S value
	localparam logic [xlen/2-1:0] nan_box = 32'hffff_ffff;

	localparam logic [xlen-1:0] s_canon_nan = {nan_box, 32'h7fc0_0000};
	localparam logic [xlen-1:0] d_canon_nan = 64'h7ff8_0000_0000_0000;

	// one-hot class mask written by fclass
	typedef logic [9:0] fclass_t;

	localparam int fc_neg_inf  = 0;
	localparam int fc_neg_norm = 1;
	localparam int fc_neg_sub  = 2;
	localparam int fc_neg_zero = 3;
	localparam int fc_pos_zero = 4;
	localparam int fc_pos_sub  = 5;
	localparam int fc_pos_norm = 6;
	localparam int fc_pos_inf  = 7;
	localparam int fc_snan     = 8;
	localparam int fc_qnan     = 9;

endpackage
